// ==== design/thrcmpl_pkg.sv ====
// ----------------------------------------------------------
// thread completion package
// thread count, per-thread mask type, stage event struct,
// completion source, wait set and wait mask bundles
// ----------------------------------------------------------

package thrcmpl_pkg;

   // four hardware threads, masks carry one bit per thread
   localparam int num_thr = 4;

   typedef logic [num_thr-1:0] thr_mask_t;

   // ----------------------------------------------------------
   // single-bit events, each applies to the thread in its stage
   // ----------------------------------------------------------
   typedef struct packed {
      logic icmiss_s1;      // instruction miss in s1
      logic ifet_err_d1;    // fetch error, thread refetches from e
      logic sw_cond_s;      // switch condition, taken in s2
      logic atr_s;          // blocks the predicted ready
      logic clear_wmo_e;    // retracted store
      logic sta_done_e;     // store to real memory done
      logic killed_done_e;  // long latency op was killed
   } stage_evt_t;

   // per-thread done vectors from the other units
   typedef struct packed {
      thr_mask_t ldst_cmplt;
      thr_mask_t branch_done;
      thr_mask_t lop_done;
      thr_mask_t fixedop_done;
      thr_mask_t ldhit;
      thr_mask_t retr_wakeup;
      thr_mask_t flush_wake;
      thr_mask_t fp_rdy;
      thr_mask_t trap_rdy;
   } cmpl_src_t;

   // per-thread causes that touch the other-wait mask
   typedef struct packed {
      thr_mask_t ldmiss;
      thr_mask_t trap;
      thr_mask_t rst_thread;
      thr_mask_t spec_ld_d;
      thr_mask_t spec_ld_g;
   } wait_set_t;

   // the three wait masks as seen by the picker
   typedef struct packed {
      thr_mask_t imiss;
      thr_mask_t other;
      thr_mask_t stbwait;
   } wait_mask_t;

endpackage

// ==== design/thr_switch_sel.sv ====
// ----------------------------------------------------------
// round-robin thread picker
// s1, s2 and e one-hot thread pipeline
// ----------------------------------------------------------

`timescale 1ns/1ps

module thr_switch_sel (
   input  logic                    clk,
   input  logic                    reset,
   input  thrcmpl_pkg::thr_mask_t  thr_active,
   input  thrcmpl_pkg::wait_mask_t wait_mask,
   input  logic                    wait_state,
   input  thrcmpl_pkg::thr_mask_t  completion,
   output thrcmpl_pkg::thr_mask_t  thr_s1,
   output thrcmpl_pkg::thr_mask_t  thr_s2,
   output thrcmpl_pkg::thr_mask_t  thr_e
);

   import thrcmpl_pkg::*;

   localparam int ptr_w = $clog2(num_thr);

   thr_mask_t        eligible;
   thr_mask_t        thr_s1_nxt;
   logic [ptr_w-1:0] last_ptr;
   logic [ptr_w-1:0] pick_idx;
   logic             pick_found;

   // ----------------------------------------------------------
   // eligible set
   // ----------------------------------------------------------
   // a thread completing this cycle may go even with its mask still set,
   // the stall flag holds every thread back
   assign eligible = ((thr_active & ~(wait_mask.imiss | wait_mask.other | wait_mask.stbwait))
                      | completion) & {num_thr{~wait_state}};

   // search starts at the thread after the last pick, wraps around
   always_comb begin
      int idx;
      idx        = 0;
      pick_found = 1'b0;
      pick_idx   = last_ptr;
      for (int off = 1; off <= num_thr; off++) begin
         idx = (int'(last_ptr) + off) % num_thr;
         if (!pick_found && eligible[idx]) begin
            pick_found = 1'b1;
            pick_idx   = ptr_w'(idx);
         end
      end
   end

   // one-hot of the winner, zero when nobody can go
   assign thr_s1_nxt = pick_found ? (thr_mask_t'(1) << pick_idx) : '0;

   // ----------------------------------------------------------
   // stage registers
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         last_ptr <= '0;
         thr_s1   <= '0;
         thr_s2   <= '0;
         thr_e    <= '0;
      end else begin
         // pointer only moves on a real pick
         if (pick_found) begin
            last_ptr <= pick_idx;
         end
         thr_s1 <= thr_s1_nxt;
         thr_s2 <= thr_s1;
         thr_e  <= thr_s2;
      end
   end

   // s1 names one thread at most
   a_s1_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(thr_s1));

endmodule

// ==== design/thr_wait_tracker.sv ====
// ----------------------------------------------------------
// thread wait tracker
// imiss and other wait masks, global stall-wait flag,
// per-thread completion from the ready strobes
// ----------------------------------------------------------

`timescale 1ns/1ps

module thr_wait_tracker (
   input  logic                    clk,
   input  logic                    reset,
   input  thrcmpl_pkg::thr_mask_t  thr_active,
   input  thrcmpl_pkg::thr_mask_t  thr_s1,
   input  thrcmpl_pkg::thr_mask_t  thr_s2,
   input  thrcmpl_pkg::thr_mask_t  thr_e,
   input  thrcmpl_pkg::stage_evt_t stage_evt,
   input  thrcmpl_pkg::thr_mask_t  imiss_rdy,
   input  thrcmpl_pkg::thr_mask_t  imiss_pred_rdy,
   input  thrcmpl_pkg::cmpl_src_t  cmpl_src,
   input  thrcmpl_pkg::wait_set_t  wait_set,
   input  logic                    en_spec_g,
   input  thrcmpl_pkg::thr_mask_t  wm_stbwait,
   input  thrcmpl_pkg::thr_mask_t  stb_retry,
   input  logic                    spc_stall,
   input  logic                    spc_resume,
   output thrcmpl_pkg::thr_mask_t  wm_imiss,
   output thrcmpl_pkg::thr_mask_t  wm_other,
   output logic                    wait_state,
   output thrcmpl_pkg::thr_mask_t  completion
);

   import thrcmpl_pkg::*;

   thr_mask_t wmi_nxt;
   thr_mask_t wmo_nxt;
   logic      wait_nxt;
   thr_mask_t clr_wmo_thr_e;
   thr_mask_t ldst_rdy;
   thr_mask_t ld_rdy;
   thr_mask_t sta_rdy;
   thr_mask_t killed_rdy;
   thr_mask_t other_rdy;
   thr_mask_t pred_rdy;
   thr_mask_t imiss_thr_rdy;

   // ----------------------------------------------------------
   // ready terms
   // ----------------------------------------------------------
   // predicted fill ready, dropped while atr_s blocks it
   assign pred_rdy      = imiss_pred_rdy & {num_thr{~stage_evt.atr_s}} & thr_active;
   assign imiss_thr_rdy = pred_rdy | imiss_rdy;

   // ld/st completion does not count for a speculated load
   assign ldst_rdy   = cmpl_src.ldst_cmplt & ~wait_set.spec_ld_g;
   // with speculation on the load already completed before the hit
   assign ld_rdy     = cmpl_src.ldhit & {num_thr{~en_spec_g}};
   // e-stage strobes belong to the thread in e
   assign sta_rdy    = thr_e & {num_thr{stage_evt.sta_done_e}};
   assign killed_rdy = thr_e & {num_thr{stage_evt.killed_done_e}};

   // any of these ends an other-wait
   assign other_rdy = ldst_rdy              |
                      cmpl_src.branch_done  |
                      ld_rdy                |
                      cmpl_src.lop_done     |
                      cmpl_src.fixedop_done |
                      killed_rdy            |
                      cmpl_src.retr_wakeup  |
                      cmpl_src.flush_wake   |
                      cmpl_src.fp_rdy       |
                      sta_rdy               |
                      cmpl_src.trap_rdy;

   // ----------------------------------------------------------
   // mask next state
   // ----------------------------------------------------------
   // imiss set from s1 miss or e fetch error, cleared by fill ready
   assign wmi_nxt = ({num_thr{stage_evt.icmiss_s1}} & thr_s1)   |
                    ({num_thr{stage_evt.ifet_err_d1}} & thr_e)  |
                    (wm_imiss & ~imiss_thr_rdy);

   // retracted store in e
   assign clr_wmo_thr_e = {num_thr{stage_evt.clear_wmo_e}} & thr_e;

   // sets only for active threads except thread reset,
   // an inactive thread drops its held bit
   assign wmo_nxt = ((({num_thr{stage_evt.sw_cond_s}} & thr_s2 & ~clr_wmo_thr_e) |
                      wait_set.trap | wait_set.ldmiss) & thr_active) |
                    wait_set.rst_thread |
                    (wm_other & thr_active &
                     ~(other_rdy | wait_set.spec_ld_d | clr_wmo_thr_e));

   // stall wins over resume in the same cycle
   assign wait_nxt = spc_stall | (wait_state & ~spc_resume);

   always_ff @(posedge clk) begin
      if (reset) begin
         wm_imiss   <= '0;
         wm_other   <= '0;
         wait_state <= 1'b0;
      end else begin
         wm_imiss   <= wmi_nxt;
         wm_other   <= wmo_nxt;
         wait_state <= wait_nxt;
      end
   end

   // ----------------------------------------------------------
   // completion, per thread
   // ----------------------------------------------------------
   // every wait is clear or satisfied now, and at least one was pending
   assign completion = (imiss_thr_rdy | ~wm_imiss)  &
                       (other_rdy | ~wm_other)      &
                       (stb_retry | ~wm_stbwait)    &
                       (wm_imiss | wm_other | wm_stbwait | {num_thr{wait_state}});

   // an idle inactive thread never sees a completion outside a stall
   a_no_idle_cmpl: assert property (@(posedge clk) disable iff (reset)
      !wait_state |->
         (completion & ~thr_active & ~(wm_imiss | wm_other | wm_stbwait)) == '0);

endmodule

// ==== design/stb_wait_tracker.sv ====
// ----------------------------------------------------------
// store-buffer wait tracker
// per-thread occupancy counters, store-buffer wait mask
// and the retry strobe
// ----------------------------------------------------------

`timescale 1ns/1ps

module stb_wait_tracker #(
   parameter int stb_depth = 4
) (
   input  logic                   clk,
   input  logic                   reset,
   input  thrcmpl_pkg::thr_mask_t thr_e,
   input  logic                   st_issue_e,
   input  thrcmpl_pkg::thr_mask_t stb_drain,
   output thrcmpl_pkg::thr_mask_t wm_stbwait,
   output thrcmpl_pkg::thr_mask_t stb_retry
);

   import thrcmpl_pkg::*;

   // enough bits to hold stb_depth itself
   localparam int cnt_w = $clog2(stb_depth + 1);

   logic [num_thr-1:0][cnt_w-1:0] stb_cnt;
   logic [num_thr-1:0][cnt_w-1:0] stb_cnt_nxt;
   thr_mask_t                     st_thr;
   thr_mask_t                     stb_full;
   thr_mask_t                     st_inc;
   thr_mask_t                     wm_nxt;

   // store from the e thread
   assign st_thr = thr_e & {num_thr{st_issue_e}};

   // ----------------------------------------------------------
   // occupancy
   // ----------------------------------------------------------
   always_comb begin
      for (int t = 0; t < num_thr; t++) begin
         stb_full[t] = (stb_cnt[t] == cnt_w'(stb_depth));
         // a store into a full buffer is not counted
         st_inc[t]   = st_thr[t] & ~stb_full[t];
         case ({st_inc[t], stb_drain[t]})
            2'b10:   stb_cnt_nxt[t] = stb_cnt[t] + 1'b1;
            2'b01:   stb_cnt_nxt[t] = stb_cnt[t] - 1'b1;
            default: stb_cnt_nxt[t] = stb_cnt[t];
         endcase
      end
   end

   // retry wakes a parked thread as soon as an entry drains
   assign stb_retry = stb_drain & wm_stbwait;
   // park on a full-buffer store, release the cycle after the retry
   assign wm_nxt    = (st_thr & stb_full) | (wm_stbwait & ~stb_retry);

   always_ff @(posedge clk) begin
      if (reset) begin
         stb_cnt    <= '0;
         wm_stbwait <= '0;
      end else begin
         stb_cnt    <= stb_cnt_nxt;
         wm_stbwait <= wm_nxt;
      end
   end

   for (genvar g = 0; g < num_thr; g++) begin : g_chk
      a_cnt_max: assert property (@(posedge clk) disable iff (reset)
         stb_cnt[g] <= cnt_w'(stb_depth));
      // drain on an empty buffer would wrap the counter
      a_no_underflow: assert property (@(posedge clk) disable iff (reset)
         stb_drain[g] |-> stb_cnt[g] != '0);
   end

endmodule

// ==== design/ifu_thr_ctl.sv ====
// ----------------------------------------------------------
// fetch thread control top level
// joins the thread picker, the wait tracker and the
// store-buffer wait tracker
// ----------------------------------------------------------

`timescale 1ns/1ps

module ifu_thr_ctl #(
   parameter int stb_depth = 4
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    en_spec_g,
   input  logic                    st_issue_e,
   input  logic                    spc_stall,
   input  logic                    spc_resume,
   input  thrcmpl_pkg::thr_mask_t  thr_active,
   input  thrcmpl_pkg::thr_mask_t  imiss_rdy,
   input  thrcmpl_pkg::thr_mask_t  imiss_pred_rdy,
   input  thrcmpl_pkg::thr_mask_t  stb_drain,
   input  thrcmpl_pkg::stage_evt_t stage_evt,
   input  thrcmpl_pkg::cmpl_src_t  cmpl_src,
   input  thrcmpl_pkg::wait_set_t  wait_set,
   output thrcmpl_pkg::thr_mask_t  completion,
   output thrcmpl_pkg::thr_mask_t  thr_s1,
   output thrcmpl_pkg::thr_mask_t  thr_e,
   output thrcmpl_pkg::thr_mask_t  stb_retry,
   output thrcmpl_pkg::wait_mask_t wait_mask,
   output logic                    wait_state
);

   import thrcmpl_pkg::*;

   thr_mask_t thr_s2;
   thr_mask_t wm_imiss;
   thr_mask_t wm_other;
   thr_mask_t wm_stbwait;

   // three masks travel as one bundle to the picker and out
   assign wait_mask = '{imiss: wm_imiss, other: wm_other, stbwait: wm_stbwait};

   thr_switch_sel u_sel (
      .clk        (clk),
      .reset      (reset),
      .thr_active (thr_active),
      .wait_mask  (wait_mask),
      .wait_state (wait_state),
      .completion (completion),
      .thr_s1     (thr_s1),
      .thr_s2     (thr_s2),
      .thr_e      (thr_e)
   );

   thr_wait_tracker u_wait (
      .clk            (clk),
      .reset          (reset),
      .thr_active     (thr_active),
      .thr_s1         (thr_s1),
      .thr_s2         (thr_s2),
      .thr_e          (thr_e),
      .stage_evt      (stage_evt),
      .imiss_rdy      (imiss_rdy),
      .imiss_pred_rdy (imiss_pred_rdy),
      .cmpl_src       (cmpl_src),
      .wait_set       (wait_set),
      .en_spec_g      (en_spec_g),
      .wm_stbwait     (wm_stbwait),
      .stb_retry      (stb_retry),
      .spc_stall      (spc_stall),
      .spc_resume     (spc_resume),
      .wm_imiss       (wm_imiss),
      .wm_other       (wm_other),
      .wait_state     (wait_state),
      .completion     (completion)
   );

   // store-buffer wait sees only the e-stage thread
   stb_wait_tracker #(
      .stb_depth (stb_depth)
   ) u_stb (
      .clk        (clk),
      .reset      (reset),
      .thr_e      (thr_e),
      .st_issue_e (st_issue_e),
      .stb_drain  (stb_drain),
      .wm_stbwait (wm_stbwait),
      .stb_retry  (stb_retry)
   );

endmodule

// ==== testbench/tb_ifu_thr_tasks.svh ====
// ----------------------------------------------------------
// directed tests for the fetch thread control
// cycle helpers, mismatch reporting, five test tasks
// ----------------------------------------------------------

// inputs change just after the rising edge
task automatic next_cycle();
   @(posedge clk);
   #5;
endtask

// combinational outputs are settled by the falling edge
task automatic mid_cycle();
   @(negedge clk);
endtask

function automatic thr_mask_t thread_bit(input int t);
   return thr_mask_t'(1) << t;
endfunction

// next free thread after the last pick with wrap-around
function automatic thr_mask_t next_pick(input thr_mask_t last, input thr_mask_t free);
   int base;
   int idx;
   base = 0;
   for (int t = 0; t < num_thr; t++) begin
      if (last[t]) base = t;
   end
   for (int off = 1; off <= num_thr; off++) begin
      idx = (base + off) % num_thr;
      if (free[idx]) return thread_bit(idx);
   end
   return '0;
endfunction

task automatic report_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
   $display("[FAIL] %s: %s expected %0h actual %0h", cur_test, what, exp, act);
   test_err++;
endtask

task automatic report_problem(input string msg);
   $display("error in %s: %s", cur_test, msg);
   test_err++;
endtask

task automatic clear_strobes();
   en_spec_g      = 1'b0;
   st_issue_e     = 1'b0;
   spc_stall      = 1'b0;
   spc_resume     = 1'b0;
   imiss_rdy      = '0;
   imiss_pred_rdy = '0;
   stb_drain      = '0;
   stage_evt      = '0;
   cmpl_src       = '0;
   wait_set       = '0;
endtask

task automatic start_test(input string name);
   cur_test = name;
   test_err = 0;
   next_cycle();
endtask

task automatic end_test();
   test_cnt++;
   total_err += test_err;
   if (test_err == 0) begin
      $display("[done] %s ok", cur_test);
   end else begin
      $display("[done] %s with %0d errors", cur_test, test_err);
      bad_tests++;
   end
endtask

// polls the registered s1 vector just after an edge
task automatic wait_for_s1(input int k);
   int n;
   n = 0;
   while (thr_s1 !== thread_bit(k) && n < 16) begin
      next_cycle();
      n++;
   end
   if (thr_s1 !== thread_bit(k)) report_problem($sformatf("thread %0d never reached s1", k));
endtask

// with only thread t active it fills the e stage every cycle
task automatic issue_stores(input int t, input int n);
   int done;
   int guard;
   done       = 0;
   guard      = 0;
   thr_active = thread_bit(t);
   while (done < n && guard < 32) begin
      st_issue_e = (thr_e == thread_bit(t));
      if (st_issue_e) done++;
      guard++;
      next_cycle();
   end
   st_issue_e = 1'b0;
   if (done < n) report_problem($sformatf("thread %0d did not reach e for its stores", t));
endtask

// ----------------------------------------------------------
// instruction miss wait and release (test 1)
// ----------------------------------------------------------
task automatic imiss_test();
   thr_mask_t kb;
   logic      seen;
   start_test("imiss_wait");
   kb = thread_bit(2);
   wait_for_s1(2);
   stage_evt.icmiss_s1 = 1'b1;
   next_cycle();
   stage_evt.icmiss_s1 = 1'b0;
   if (wait_mask.imiss !== kb) report_mismatch("wm_imiss after miss", kb, wait_mask.imiss);
   // parked thread is skipped
   repeat (4) begin
      next_cycle();
      if ((thr_s1 & kb) != '0) report_mismatch("thr_s1 while parked", 0, thr_s1);
   end
   imiss_rdy = kb;
   mid_cycle();
   if (completion !== kb) report_mismatch("completion on imiss ready", kb, completion);
   next_cycle();
   imiss_rdy = '0;
   if (wait_mask.imiss !== '0) report_mismatch("wm_imiss after ready", 0, wait_mask.imiss);
   seen = (thr_s1 == kb);
   for (int i = 1; i < 4 && !seen; i++) begin
      next_cycle();
      seen = (thr_s1 == kb);
   end
   if (!seen) report_problem("thread 2 not back in s1 within 4 cycles of its ready");
   end_test();
endtask

// ----------------------------------------------------------
// other-wait set causes and each done vector (test 2)
// ----------------------------------------------------------
task automatic other_wait_test();
   thr_mask_t kb;
   cmpl_src_t src;
   start_test("other_wait");
   kb = thread_bit(1);
   // vector 0 is trap_rdy and vector 8 is ldst_cmplt
   for (int i = 0; i < 9; i++) begin
      if (i % 2 == 0) wait_set.trap = kb;
      else wait_set.ldmiss = kb;
      next_cycle();
      wait_set = '0;
      if (wait_mask.other !== kb) report_mismatch("wm_other after set", kb, wait_mask.other);
      src = '0;
      src[i*num_thr +: num_thr] = kb;
      cmpl_src = src;
      mid_cycle();
      if (completion !== kb)
         report_mismatch($sformatf("completion on done vector %0d", i), kb, completion);
      next_cycle();
      cmpl_src = '0;
      if (wait_mask.other !== '0) report_mismatch("wm_other after done", 0, wait_mask.other);
   end
   // ld/st completion is ignored for a speculated load
   wait_set.trap = kb;
   next_cycle();
   wait_set.trap       = '0;
   wait_set.spec_ld_g  = kb;
   cmpl_src.ldst_cmplt = kb;
   mid_cycle();
   if (completion !== '0) report_mismatch("completion on spec ldst_cmplt", 0, completion);
   next_cycle();
   wait_set = '0;
   cmpl_src = '0;
   if (wait_mask.other !== kb) report_mismatch("wm_other after spec ldst", kb, wait_mask.other);
   // load hit ignored with speculation on
   en_spec_g      = 1'b1;
   cmpl_src.ldhit = kb;
   mid_cycle();
   if (completion !== '0) report_mismatch("completion on ldhit with en_spec_g", 0, completion);
   next_cycle();
   en_spec_g = 1'b0;
   cmpl_src  = '0;
   if (wait_mask.other !== kb) report_mismatch("wm_other after ldhit", kb, wait_mask.other);
   cmpl_src.trap_rdy = kb;
   next_cycle();
   cmpl_src = '0;
   end_test();
endtask

// ----------------------------------------------------------
// both masks on one thread and thread reset (test 3)
// ----------------------------------------------------------
task automatic joint_wait_test();
   thr_mask_t kb;
   start_test("joint_wait");
   kb = thread_bit(3);
   for (int round = 0; round < 2; round++) begin
      wait_for_s1(3);
      stage_evt.icmiss_s1 = 1'b1;
      wait_set.trap       = kb;
      next_cycle();
      stage_evt = '0;
      wait_set  = '0;
      if (wait_mask.imiss !== kb) report_mismatch("wm_imiss joint", kb, wait_mask.imiss);
      if (wait_mask.other !== kb) report_mismatch("wm_other joint", kb, wait_mask.other);
      imiss_rdy = kb;
      // second round brings the other ready in the same cycle
      if (round == 1) cmpl_src.branch_done = kb;
      mid_cycle();
      if (round == 0 && completion !== '0)
         report_mismatch("completion on imiss ready alone", 0, completion);
      if (round == 1 && completion !== kb)
         report_mismatch("completion on both readies", kb, completion);
      next_cycle();
      imiss_rdy            = '0;
      cmpl_src.branch_done = kb;
      next_cycle();
      cmpl_src = '0;
   end
   // reset of an inactive thread still sets its other wait
   thr_active           = ~kb;
   wait_set.rst_thread = kb;
   next_cycle();
   wait_set = '0;
   if (wait_mask.other !== kb) report_mismatch("wm_other on thread reset", kb, wait_mask.other);
   next_cycle();
   thr_active = '1;
   end_test();
endtask

// ----------------------------------------------------------
// store buffer full wait and retry (test 4)
// ----------------------------------------------------------
task automatic stb_wait_test();
   thr_mask_t kb;
   thr_mask_t jb;
   start_test("stb_wait");
   kb = thread_bit(0);
   jb = thread_bit(2);
   // thread 2 fills its own buffer first
   issue_stores(2, stb_depth);
   issue_stores(0, stb_depth);
   if (wait_mask.stbwait !== '0) report_mismatch("wm_stbwait at full", 0, wait_mask.stbwait);
   issue_stores(0, 1);
   if (wait_mask.stbwait !== kb) report_mismatch("wm_stbwait on overflow", kb, wait_mask.stbwait);
   stb_drain = kb | jb;
   mid_cycle();
   if (stb_retry !== kb) report_mismatch("stb_retry on drain", kb, stb_retry);
   if (completion !== kb) report_mismatch("completion on drain", kb, completion);
   next_cycle();
   if (wait_mask.stbwait !== '0) report_mismatch("wm_stbwait after retry", 0, wait_mask.stbwait);
   // empty both buffers
   repeat (stb_depth - 1) next_cycle();
   stb_drain  = '0;
   thr_active = '1;
   end_test();
endtask

// ----------------------------------------------------------
// stall wait and selection around parked threads (test 5)
// ----------------------------------------------------------
task automatic stall_select_test();
   int        order [num_thr];
   int        j;
   int        tmp;
   thr_mask_t parked;
   thr_mask_t prev;
   thr_mask_t prev2;
   thr_mask_t seen;
   start_test("stall_select");
   spc_stall = 1'b1;
   next_cycle();
   spc_stall = 1'b0;
   if (wait_state !== 1'b1) report_mismatch("wait_state after stall", 1, wait_state);
   mid_cycle();
   if (completion !== '1) report_mismatch("completion during stall", 4'hf, completion);
   repeat (3) begin
      next_cycle();
      if (thr_s1 !== '0) report_mismatch("thr_s1 during stall", 0, thr_s1);
   end
   spc_resume = 1'b1;
   next_cycle();
   spc_resume = 1'b0;
   if (wait_state !== 1'b0) report_mismatch("wait_state after resume", 0, wait_state);
   if (thr_s1 !== '0) report_mismatch("thr_s1 right after resume", 0, thr_s1);
   next_cycle();
   if (thr_s1 == '0) report_problem("no thread picked after resume");
   for (int r = 1; r < num_thr; r++) begin
      // shuffle the threads and park the first r
      for (int i = 0; i < num_thr; i++) order[i] = i;
      for (int i = num_thr - 1; i > 0; i--) begin
         j        = int'($urandom % (i + 1));
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      parked = '0;
      for (int i = 0; i < r; i++) parked |= thread_bit(order[i]);
      wait_set.ldmiss = parked;
      next_cycle();
      wait_set = '0;
      // s1 may still hold a pick made before the park
      next_cycle();
      seen  = '0;
      prev  = '0;
      prev2 = '0;
      for (int c = 0; c < 8; c++) begin
         if (c > 0 && thr_s1 !== next_pick(prev, ~parked))
            report_mismatch("thr_s1 round-robin", next_pick(prev, ~parked), thr_s1);
         if ((thr_s1 & parked) != '0 || thr_s1 == '0)
            report_problem($sformatf("thr_s1 %b names a parked thread or none", thr_s1));
         // e trails s1 by two stages
         if (c > 1 && thr_e !== prev2)
            report_mismatch("thr_e two cycles after thr_s1", prev2, thr_e);
         seen |= thr_s1;
         if (c == 3 && seen != ~parked)
            report_problem($sformatf("free threads %b missed s1 for 4 cycles", ~parked & ~seen));
         prev2 = prev;
         prev  = thr_s1;
         next_cycle();
      end
      cmpl_src.trap_rdy = parked;
      mid_cycle();
      if (completion !== parked) report_mismatch("completion on release", parked, completion);
      next_cycle();
      cmpl_src = '0;
      if (wait_mask.other !== '0) report_mismatch("wm_other after release", 0, wait_mask.other);
   end
   end_test();
endtask

// ==== testbench/tb_ifu_thr_ctl.sv ====
// ----------------------------------------------------------
// testbench for the fetch thread control
// clock, reset, dut0, timeout counter, test sequence
// and the closing summary
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_ifu_thr_ctl;

   import thrcmpl_pkg::*;

   localparam int stb_depth  = 4;
   // the five tests take a few hundred cycles at most
   localparam int max_cycles = 2000;

   logic       clk;
   logic       reset;
   logic       en_spec_g;
   logic       st_issue_e;
   logic       spc_stall;
   logic       spc_resume;
   thr_mask_t  thr_active;
   thr_mask_t  imiss_rdy;
   thr_mask_t  imiss_pred_rdy;
   thr_mask_t  stb_drain;
   stage_evt_t stage_evt;
   cmpl_src_t  cmpl_src;
   wait_set_t  wait_set;
   thr_mask_t  completion;
   thr_mask_t  thr_s1;
   thr_mask_t  thr_e;
   thr_mask_t  stb_retry;
   wait_mask_t wait_mask;
   logic       wait_state;

   // bookkeeping for the per-test lines and the summary
   int    cycle_cnt = 0;
   int    test_cnt  = 0;
   int    test_err  = 0;
   int    bad_tests = 0;
   int    total_err = 0;
   string cur_test;
   // seed for the thread order in the selection test
   int unsigned rand_seed = 32'h9e38_fd73;

   ifu_thr_ctl #(
      .stb_depth (stb_depth)
   ) dut0 (
      .clk            (clk),
      .reset          (reset),
      .en_spec_g      (en_spec_g),
      .st_issue_e     (st_issue_e),
      .spc_stall      (spc_stall),
      .spc_resume     (spc_resume),
      .thr_active     (thr_active),
      .imiss_rdy      (imiss_rdy),
      .imiss_pred_rdy (imiss_pred_rdy),
      .stb_drain      (stb_drain),
      .stage_evt      (stage_evt),
      .cmpl_src       (cmpl_src),
      .wait_set       (wait_set),
      .completion     (completion),
      .thr_s1         (thr_s1),
      .thr_e          (thr_e),
      .stb_retry      (stb_retry),
      .wait_mask      (wait_mask),
      .wait_state     (wait_state)
   );

   // 100 ns clock
   initial clk = 1'b0;
   always #50 clk = ~clk;

   // ----------------------------------------------------------
   // run limit
   // ----------------------------------------------------------
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= max_cycles) begin
         $display("run timed out after %0d cycles", max_cycles);
         $display("tests failed");
         $finish;
      end
   end

   `include "tb_ifu_thr_tasks.svh"

   initial begin
      void'($urandom(rand_seed));
      reset      = 1'b1;
      thr_active = '0;
      clear_strobes();
      // reset held over 8 rising edges
      repeat (8) @(posedge clk);
      #5;
      reset      = 1'b0;
      thr_active = '1;
      imiss_test();
      other_wait_test();
      joint_wait_test();
      stb_wait_test();
      stall_select_test();
      $display("summary: %0d tests run, %0d with errors, %0d checks wrong",
               test_cnt, bad_tests, total_err);
      if (total_err == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== ifu_thr_ctl.f ====
+incdir+testbench
design/thrcmpl_pkg.sv
design/thr_switch_sel.sv
design/thr_wait_tracker.sv
design/stb_wait_tracker.sv
design/ifu_thr_ctl.sv
testbench/tb_ifu_thr_ctl.sv

// ==== Bender.yml ====
package:
  name: ifu_thr_ctl

sources:
  - files:
      - design/thrcmpl_pkg.sv
      - design/thr_switch_sel.sv
      - design/thr_wait_tracker.sv
      - design/stb_wait_tracker.sv
      - design/ifu_thr_ctl.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_ifu_thr_ctl.sv
